// File: rtl/piso_defines.svh
`ifndef PISO_DEFINES_SVH
`define PISO_DEFINES_SVH

// width of one wide input word
`define PISO_DIN_WIDTH 128

// width of one output lane, must divide the input width
`define PISO_DOUT_WIDTH 32

// fifo entries, also the upstream credits after reset
// must be a power of two
`define PISO_FIFO_DEPTH 8

`endif

// File: rtl/piso_pkg.sv
`include "piso_defines.svh"

package piso_pkg;

    localparam int LANES      = `PISO_DIN_WIDTH / `PISO_DOUT_WIDTH;
    localparam int LANE_IDX_W = (LANES > 1) ? $clog2(LANES) : 1;
    localparam int ADDR_W     = $clog2(`PISO_FIFO_DEPTH);

    typedef logic [`PISO_DOUT_WIDTH-1:0] lane_t;

    // written as raw bits, read back lane by lane (lane 0 in the low bits)
    typedef union packed {
        logic [`PISO_DIN_WIDTH-1:0] raw;
        lane_t [LANES-1:0]          lanes;
    } wide_word_u;

    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // extra msb is the wrap bit
    typedef logic [ADDR_W:0] ptr_t;

endpackage

// File: rtl/bram_infer.sv
`timescale 1ns/1ps

module bram_infer #(
    parameter int DEPTH      = 8,
    parameter int DATA_WIDTH = 128
) (
    input  logic                     clk,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  piso_pkg::wide_word_u     wdata,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output piso_pkg::wide_word_u     rdata
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    if (DATA_WIDTH != $bits(piso_pkg::wide_word_u)) begin : g_width_check
        $error("bram_infer: DATA_WIDTH differs from the wide word width");
    end

    // simple dual port, write side
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds its value between reads
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: rtl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  din_valid,
    output logic                  din_ready,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  dout_valid,
    input  logic                  dout_ready
);

    logic [DATA_WIDTH-1:0] skid_data;
    logic                  skid_valid;
    logic                  in_xfer;
    logic                  out_free;

    // ready comes straight from a flop, never from dout_ready
    assign din_ready = !skid_valid;

    assign in_xfer  = din_valid && din_ready;
    assign out_free = !dout_valid || dout_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            if (skid_valid) begin
                // drain the skid entry first
                dout_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                dout_valid <= in_xfer;
            end
        end else if (in_xfer) begin
            // output stalled, park the word
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                dout <= skid_data;
            end else if (in_xfer) begin
                dout <= din;
            end
        end
        if (!out_free && in_xfer) begin
            skid_data <= din;
        end
    end

    // valid/ready output contract
    a_dout_hold: assert property (
        @(posedge clk) disable iff (rst)
        dout_valid && !dout_ready |=> dout_valid && $stable(dout)
    ) else $error("skid_buffer: output dropped or changed under back-pressure");

endmodule

// File: rtl/piso_fifo.sv
`timescale 1ns/1ps
`include "piso_defines.svh"

module piso_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 din_valid,
    input  piso_pkg::wide_word_u din,
    input  logic                 pop,
    output piso_pkg::wide_word_u rd_word,
    output logic                 empty,
    output logic                 credit_return
);

    localparam int AW = piso_pkg::ADDR_W;

    piso_pkg::ptr_t wr_ptr;
    piso_pkg::ptr_t rd_ptr;
    logic           full;
    logic           wr_en;

    if ((1 << AW) != `PISO_FIFO_DEPTH) begin : g_depth_check
        $error("piso_fifo: PISO_FIFO_DEPTH must be a power of two");
    end

    // same address with different wrap bits means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // a full fifo drops the word, the credit check below flags it
    assign wr_en = din_valid && !full;

    // one credit goes back upstream for each word that leaves
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + piso_pkg::ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + piso_pkg::ptr_t'(1);
        end
    end

    bram_infer #(
        .DEPTH      (`PISO_FIFO_DEPTH),
        .DATA_WIDTH (`PISO_DIN_WIDTH)
    ) bram_i (
        .clk   (clk),
        .wen   (wr_en),
        .waddr (wr_ptr[AW-1:0]),
        .wdata (din),
        .ren   (pop),
        .raddr (rd_ptr[AW-1:0]),
        .rdata (rd_word)
    );

    // upstream wrote without holding a credit
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst) din_valid |-> !full
    ) else $error("piso_fifo: write while full, credit violation");

    // serializer must only pop a word that is there
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    ) else $error("piso_fifo: pop while empty");

endmodule

// File: rtl/piso_serializer.sv
`timescale 1ns/1ps
`include "piso_defines.svh"

module piso_serializer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 empty,
    input  piso_pkg::wide_word_u rd_word,
    output logic                 pop,
    output piso_pkg::lane_t      lane,
    output logic                 lane_valid,
    input  logic                 lane_ready
);

    localparam piso_pkg::lane_idx_t LAST_LANE = piso_pkg::lane_idx_t'(piso_pkg::LANES - 1);

    logic                loaded;
    piso_pkg::lane_idx_t lane_cnt;
    logic                xfer;
    logic                last_xfer;

    if ((`PISO_DIN_WIDTH % `PISO_DOUT_WIDTH) != 0) begin : g_width_check
        $error("piso_serializer: output width must divide the input width");
    end

    assign lane_valid = loaded;
    assign lane       = rd_word.lanes[lane_cnt];

    assign xfer      = lane_valid && lane_ready;
    assign last_xfer = xfer && (lane_cnt == LAST_LANE);

    // fetch the next word when idle, or while the last lane leaves
    // so that its lane 0 follows without a gap
    assign pop = !empty && (!loaded || last_xfer);

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (pop) begin
            loaded <= 1'b1;
        end else if (last_xfer) begin
            loaded <= 1'b0;
        end
    end

    // counter only moves on a transfer so back-pressure freezes it
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_cnt <= '0;
        end else if (xfer) begin
            if (lane_cnt == LAST_LANE) begin
                lane_cnt <= '0;
            end else begin
                lane_cnt <= lane_cnt + piso_pkg::lane_idx_t'(1);
            end
        end
    end

    // relies on the fifo holding rd_word until the next pop
    a_lane_stable: assert property (
        @(posedge clk) disable iff (rst)
        lane_valid && !lane_ready |=> lane_valid && $stable(lane)
    ) else $error("piso_serializer: lane changed while stalled");

endmodule

// File: rtl/piso_top.sv
`timescale 1ns/1ps
`include "piso_defines.svh"

module piso_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`PISO_DIN_WIDTH-1:0]  din,
    input  logic                        din_valid,
    output logic                        credit_return,
    output logic [`PISO_DOUT_WIDTH-1:0] dout,
    output logic                        dout_valid,
    input  logic                        dout_ready
);

    piso_pkg::wide_word_u fifo_word;
    logic                 fifo_empty;
    logic                 fifo_pop;
    piso_pkg::lane_t      ser_lane;
    logic                 ser_lane_valid;
    logic                 ser_lane_ready;

    piso_fifo fifo_i (
        .clk           (clk),
        .rst           (rst),
        .din_valid     (din_valid),
        .din           (din),
        .pop           (fifo_pop),
        .rd_word       (fifo_word),
        .empty         (fifo_empty),
        .credit_return (credit_return)
    );

    piso_serializer serializer_i (
        .clk        (clk),
        .rst        (rst),
        .empty      (fifo_empty),
        .rd_word    (fifo_word),
        .pop        (fifo_pop),
        .lane       (ser_lane),
        .lane_valid (ser_lane_valid),
        .lane_ready (ser_lane_ready)
    );

    // output register stage with back-pressure
    skid_buffer #(
        .DATA_WIDTH (`PISO_DOUT_WIDTH)
    ) skid_i (
        .clk        (clk),
        .rst        (rst),
        .din        (ser_lane),
        .din_valid  (ser_lane_valid),
        .din_ready  (ser_lane_ready),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready)
    );

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, half a period per phase
    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: tb/tb_piso.sv
`timescale 1ns/1ps
`include "piso_defines.svh"

module tb_piso;

    localparam int DEPTH     = `PISO_FIFO_DEPTH;
    localparam int LANES     = piso_pkg::LANES;
    localparam int NUM_REC   = 16;
    localparam int REC_LEN   = 1 + LANES;
    localparam int WAIT_MAX  = 2000;
    localparam int MODE_LOW  = 0;
    localparam int MODE_HIGH = 1;
    localparam int MODE_RAND = 2;
    localparam logic [31:0] SEED = 32'h9c2a3bbf;

    logic                        clk;
    logic                        rst;
    logic [`PISO_DIN_WIDTH-1:0]  din;
    logic                        din_valid;
    logic                        credit_return;
    logic [`PISO_DOUT_WIDTH-1:0] dout;
    logic                        dout_valid;
    logic                        dout_ready;

    // records of one word followed by lanes 0 to LANES-1
    logic [`PISO_DIN_WIDTH-1:0] pat_mem [NUM_REC*REC_LEN];
    piso_pkg::lane_t            exp_q [$];
    logic [31:0]                ready_state;
    logic [31:0]                gap_state;
    logic                       timed_out;
    int ready_mode;
    int credits;
    int credit_pulses;
    int valid_cycles;
    int lanes_out;
    int first_xfer;
    int last_xfer;
    int errors;
    int checks;
    int tests_run;
    int tests_bad;
    int test_errors;
    int mark;
    int written;

    clk_gen #(.PERIOD(40)) clk_gen_i (.clk(clk));

    piso_top piso_top_i (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .din_valid     (din_valid),
        .credit_return (credit_return),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .dout_ready    (dout_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_lane(input string name, input piso_pkg::lane_t exp,
                              input piso_pkg::lane_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // later waits return at once so the run reaches its end quickly
    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    // writes one word once a credit is held
    task automatic write_word(input int rec);
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            @(posedge clk);
            din_valid <= 1'b0;
            waited++;
            if (waited > WAIT_MAX) begin
                report_timeout("a returned credit");
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            din       <= pat_mem[rec*REC_LEN];
            din_valid <= 1'b1;
            credits--;
            for (int l = 1; l <= LANES; l++) begin
                exp_q.push_back(pat_mem[rec*REC_LEN + l][`PISO_DOUT_WIDTH-1:0]);
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            din_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            din_valid <= 1'b0;
            waited++;
            if (waited > WAIT_MAX) begin
                report_timeout("the expected lanes to drain");
            end
        end
    endtask

    // mode changes away from the edge that samples it
    task automatic set_ready(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (ready_mode == MODE_RAND) begin
                ready_state = xorshift32(ready_state);
                dout_ready <= (ready_state[1:0] != 2'b00);
            end else begin
                dout_ready <= (ready_mode == MODE_HIGH);
            end
        end
    endtask

    // outputs are stable at the falling edge
    task automatic watch_output();
        piso_pkg::lane_t exp_lane;
        int              cycle;
        cycle = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (!rst && credit_return) begin
                credits++;
                credit_pulses++;
            end
            if (!rst && dout_valid) begin
                valid_cycles++;
            end
            if (!rst && dout_valid && dout_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("lane %h left the DUT while no lane was expected", dout);
                end else begin
                    exp_lane = exp_q.pop_front();
                    check_lane("dout", exp_lane, dout);
                end
                lanes_out++;
                if (first_xfer < 0) begin
                    first_xfer = cycle;
                end
                last_xfer = cycle;
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        din         = '0;
        din_valid   = 1'b0;
        dout_ready  = 1'b0;
        timed_out   = 1'b0;
        ready_mode  = MODE_LOW;
        ready_state = SEED;
        gap_state   = xorshift32(SEED);
        credits     = DEPTH;
        first_xfer  = -1;
        $readmemh("tb/piso_patterns.mem", pat_mem);
        fork
            drive_ready();
            watch_output();
        join_none
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_errors = errors;
        idle(16);
        check_count("dout_valid cycles", 0, valid_cycles);
        check_count("credit_return pulses", 0, credit_pulses);
        end_test("reset");

        test_errors = errors;
        set_ready(MODE_HIGH);
        mark = lanes_out;
        write_word(0);
        wait_drain();
        check_count("lanes out", LANES, lanes_out - mark);
        end_test("lane order");

        test_errors = errors;
        mark = lanes_out;
        first_xfer = -1;
        for (int r = 1; r <= DEPTH; r++) begin
            write_word(r);
        end
        wait_drain();
        check_count("lanes out", DEPTH * LANES, lanes_out - mark);
        check_count("cycles first to last lane", DEPTH * LANES, last_xfer - first_xfer + 1);
        end_test("streaming");

        test_errors = errors;
        set_ready(MODE_RAND);
        mark = lanes_out;
        for (int r = 0; r < NUM_REC; r++) begin
            gap_state = xorshift32(gap_state);
            idle(int'(gap_state[1:0]));
            write_word(r);
        end
        wait_drain();
        check_count("lanes out", NUM_REC * LANES, lanes_out - mark);
        check_count("credits", DEPTH, credits);
        end_test("back-pressure");

        test_errors = errors;
        set_ready(MODE_LOW);
        written = 0;
        while (credits > 0 && written <= DEPTH) begin
            write_word((written + 3) % NUM_REC);
            written++;
        end
        idle(10);
        mark = credit_pulses;
        idle(10);
        check_count("credit pulses while stalled", 0, credit_pulses - mark);
        check_count("credits left", 0, credits);
        // a full fifo plus the word held by the serializer
        check_count("words taken while stalled", DEPTH + 1, written);
        mark = credit_pulses;
        set_ready(MODE_HIGH);
        wait_drain();
        check_count("credit pulses after release", DEPTH, credit_pulses - mark);
        check_count("credits", DEPTH, credits);
        end_test("credits");

        finish_run();
    end

endmodule

// File: tb/piso_patterns.mem
// record: one 128-bit input word, then on the next line its 32-bit lanes 0 to 3
// lane 0 is the lowest 32 bits of the word
00112233445566778899aabbccddeeff
ccddeeff 8899aabb 44556677 00112233
0f1e2d3c4b5a69788796a5b4c3d2e1f0
c3d2e1f0 8796a5b4 4b5a6978 0f1e2d3c
deadbeefcafebabe0123456789abcdef
89abcdef 01234567 cafebabe deadbeef
ffffffff0000000055555555aaaaaaaa
aaaaaaaa 55555555 00000000 ffffffff
13579bdf2468ace0fedcba9876543210
76543210 fedcba98 2468ace0 13579bdf
a5a5a5a55a5a5a5a3c3c3c3cc3c3c3c3
c3c3c3c3 3c3c3c3c 5a5a5a5a a5a5a5a5
10000001200000023000000340000004
40000004 30000003 20000002 10000001
8badf00dfeedface0badc0de1337c0de
1337c0de 0badc0de feedface 8badf00d
00000001000000020000000300000004
00000004 00000003 00000002 00000001
7fffffff80000000fffffffe00000001
00000001 fffffffe 80000000 7fffffff
9e3779b97f4a7c15f39cc0605cedc834
5cedc834 f39cc060 7f4a7c15 9e3779b9
0123456789abcdeffedcba9876543210
76543210 fedcba98 89abcdef 01234567
c0ffee00baadf00d11223344aabbccdd
aabbccdd 11223344 baadf00d c0ffee00
6a09e667bb67ae853c6ef372a54ff53a
a54ff53a 3c6ef372 bb67ae85 6a09e667
510e527f9b05688c1f83d9ab5be0cd19
5be0cd19 1f83d9ab 9b05688c 510e527f
428a2f9871374491b5c0fbcfe9b5dba5
e9b5dba5 b5c0fbcf 71374491 428a2f98

// File: tb.f
+incdir+rtl
rtl/piso_pkg.sv
rtl/bram_infer.sv
rtl/skid_buffer.sv
rtl/piso_fifo.sv
rtl/piso_serializer.sv
rtl/piso_top.sv
tb/clk_gen.sv
tb/tb_piso.sv

// File: Makefile
TOOL       = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_piso
FILELIST   = tb.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = sim passed
FAIL_MSG   = sim failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
